//--- axi_lite_mem_top.sv
/*
  AXI4-Lite register store, top level
  split, read and write subordinates, shared register array
*/
`timescale 1ns/1ps

module axi_lite_mem_top #(
  parameter int unsigned Words   = axi_lite_pkg::DEF_WORDS,
  parameter int unsigned MaxTxns = axi_lite_pkg::DEF_MAX_TXNS
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  axi_lite_pkg::addr_t aw_addr_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_lite_pkg::data_t w_data_i,
  input  axi_lite_pkg::strb_t w_strb_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  output axi_lite_pkg::resp_t b_resp_o,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  input  axi_lite_pkg::addr_t ar_addr_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  output axi_lite_pkg::data_t r_data_o,
  output axi_lite_pkg::resp_t r_resp_o,
  output logic                r_valid_o,
  input  logic                r_ready_i
);

  // --------------------
  // Read side wires
  // --------------------

  axi_lite_pkg::addr_t rd_ar_addr;
  logic                rd_ar_valid;
  logic                rd_ar_ready;
  axi_lite_pkg::data_t rd_r_data;
  axi_lite_pkg::resp_t rd_r_resp;
  logic                rd_r_valid;
  logic                rd_r_ready;
  logic                rd_mem_req;
  axi_lite_pkg::addr_t rd_mem_addr;
  logic                rd_mem_gnt;
  axi_lite_pkg::data_t rd_mem_data;

  // --------------------
  // Write side wires
  // --------------------

  axi_lite_pkg::addr_t wr_aw_addr;
  logic                wr_aw_valid;
  logic                wr_aw_ready;
  axi_lite_pkg::data_t wr_w_data;
  axi_lite_pkg::strb_t wr_w_strb;
  logic                wr_w_valid;
  logic                wr_w_ready;
  axi_lite_pkg::resp_t wr_b_resp;
  logic                wr_b_valid;
  logic                wr_b_ready;
  logic                wr_mem_req;
  axi_lite_pkg::addr_t wr_mem_addr;
  axi_lite_pkg::data_t wr_mem_data;
  axi_lite_pkg::strb_t wr_mem_strb;
  logic                wr_mem_gnt;

  axi_rw_split #(
    .MaxTxns(MaxTxns)
  ) u_split (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .aw_addr_i     (aw_addr_i),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_o    (aw_ready_o),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_valid_i     (w_valid_i),
    .w_ready_o     (w_ready_o),
    .b_resp_o      (b_resp_o),
    .b_valid_o     (b_valid_o),
    .b_ready_i     (b_ready_i),
    .ar_addr_i     (ar_addr_i),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_o    (ar_ready_o),
    .r_data_o      (r_data_o),
    .r_resp_o      (r_resp_o),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .rd_ar_addr_o  (rd_ar_addr),
    .rd_ar_valid_o (rd_ar_valid),
    .rd_ar_ready_i (rd_ar_ready),
    .rd_r_data_i   (rd_r_data),
    .rd_r_resp_i   (rd_r_resp),
    .rd_r_valid_i  (rd_r_valid),
    .rd_r_ready_o  (rd_r_ready),
    .wr_aw_addr_o  (wr_aw_addr),
    .wr_aw_valid_o (wr_aw_valid),
    .wr_aw_ready_i (wr_aw_ready),
    .wr_w_data_o   (wr_w_data),
    .wr_w_strb_o   (wr_w_strb),
    .wr_w_valid_o  (wr_w_valid),
    .wr_w_ready_i  (wr_w_ready),
    .wr_b_resp_i   (wr_b_resp),
    .wr_b_valid_i  (wr_b_valid),
    .wr_b_ready_o  (wr_b_ready)
  );

  axi_lite_read_sub #(
    .Words(Words)
  ) u_read_sub (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ar_addr_i   (rd_ar_addr),
    .ar_valid_i  (rd_ar_valid),
    .ar_ready_o  (rd_ar_ready),
    .r_data_o    (rd_r_data),
    .r_resp_o    (rd_r_resp),
    .r_valid_o   (rd_r_valid),
    .r_ready_i   (rd_r_ready),
    .mem_req_o   (rd_mem_req),
    .mem_addr_o  (rd_mem_addr),
    .mem_gnt_i   (rd_mem_gnt),
    .mem_rdata_i (rd_mem_data)
  );

  axi_lite_write_sub #(
    .Words(Words)
  ) u_write_sub (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .aw_addr_i   (wr_aw_addr),
    .aw_valid_i  (wr_aw_valid),
    .aw_ready_o  (wr_aw_ready),
    .w_data_i    (wr_w_data),
    .w_strb_i    (wr_w_strb),
    .w_valid_i   (wr_w_valid),
    .w_ready_o   (wr_w_ready),
    .b_resp_o    (wr_b_resp),
    .b_valid_o   (wr_b_valid),
    .b_ready_i   (wr_b_ready),
    .mem_req_o   (wr_mem_req),
    .mem_addr_o  (wr_mem_addr),
    .mem_wdata_o (wr_mem_data),
    .mem_strb_o  (wr_mem_strb),
    .mem_gnt_i   (wr_mem_gnt)
  );

  // Shared array, read and write subordinates on separate request ports
  reg_mem #(
    .Words(Words)
  ) u_reg_mem (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rd_req_i  (rd_mem_req),
    .rd_addr_i (rd_mem_addr),
    .rd_gnt_o  (rd_mem_gnt),
    .rd_data_o (rd_mem_data),
    .wr_req_i  (wr_mem_req),
    .wr_addr_i (wr_mem_addr),
    .wr_data_i (wr_mem_data),
    .wr_strb_i (wr_mem_strb),
    .wr_gnt_o  (wr_mem_gnt)
  );

endmodule

//--- axi_lite_pkg.sv
/*
  Shared AXI4-Lite types, response codes and default sizes
*/

package axi_lite_pkg;

  // --------------------
  // Bus field types
  // --------------------

  // Byte address of one access
  typedef logic [31:0] addr_t;
  // One data word
  typedef logic [31:0] data_t;
  // One strobe bit per data byte
  typedef logic [3:0]  strb_t;
  // Response code on B and R
  typedef logic [1:0]  resp_t;

  // --------------------
  // Response codes
  // --------------------

  // Access completed normally
  localparam resp_t RESP_OKAY   = 2'b00;
  // Address beyond the register array
  localparam resp_t RESP_SLVERR = 2'b10;

  // --------------------
  // Defaults
  // --------------------

  // Words in the register array
  localparam int unsigned DEF_WORDS    = 16;
  // Outstanding transactions per direction
  localparam int unsigned DEF_MAX_TXNS = 2;

endpackage

//--- axi_lite_read_sub.sv
/*
  AXI4-Lite read subordinate with range check
  and a two-entry in-order response queue
*/
`timescale 1ns/1ps

module axi_lite_read_sub #(
  parameter int unsigned Words = axi_lite_pkg::DEF_WORDS
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  axi_lite_pkg::addr_t ar_addr_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  output axi_lite_pkg::data_t r_data_o,
  output axi_lite_pkg::resp_t r_resp_o,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  // Memory port
  output logic                mem_req_o,
  output axi_lite_pkg::addr_t mem_addr_o,
  input  logic                mem_gnt_i,
  input  axi_lite_pkg::data_t mem_rdata_i
);

  localparam int unsigned Depth = 2;

  logic                pend_q;
  logic                rd_q;
  logic                err_q;
  axi_lite_pkg::addr_t addr_q;
  axi_lite_pkg::data_t q_data [Depth];
  axi_lite_pkg::resp_t q_resp [Depth];
  logic                wr_ptr_q;
  logic                rd_ptr_q;
  logic [1:0]          cnt_q;
  logic [1:0]          used;
  logic                ar_hs;
  logic                in_range;
  logic                push;
  logic                pop;

  // --------------------
  // Request side
  // --------------------

  assign in_range = (ar_addr_i >> 2) < axi_lite_pkg::addr_t'(Words);

  // Queue slots plus the one read that may still be in flight
  assign used       = cnt_q + {1'b0, pend_q} + {1'b0, rd_q} + {1'b0, err_q};
  assign ar_ready_o = ~pend_q & (used < 2'(Depth));
  assign ar_hs      = ar_valid_i & ar_ready_o;

  assign mem_req_o  = pend_q;
  assign mem_addr_o = addr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
      rd_q   <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      // Request stays up until the arbiter grants it
      pend_q <= ar_hs ? in_range : (pend_q & ~mem_gnt_i);
      // Data shows up on mem_rdata_i one cycle after the grant
      rd_q   <= pend_q & mem_gnt_i;
      err_q  <= ar_hs & ~in_range;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      addr_q <= ar_addr_i;
    end
  end

  // --------------------
  // Response queue
  // --------------------

  assign push      = rd_q | err_q;
  assign pop       = r_valid_o & r_ready_i;
  assign r_valid_o = (cnt_q != 2'd0);
  assign r_data_o  = q_data[rd_ptr_q];
  assign r_resp_o  = q_resp[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      wr_ptr_q <= wr_ptr_q ^ push;
      rd_ptr_q <= rd_ptr_q ^ pop;
      cnt_q    <= cnt_q + {1'b0, push} - {1'b0, pop};
    end
  end

  // Out-of-range reads return zero data
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_data[wr_ptr_q] <= err_q ? '0 : mem_rdata_i;
      q_resp[wr_ptr_q] <= err_q ? axi_lite_pkg::RESP_SLVERR : axi_lite_pkg::RESP_OKAY;
    end
  end

  // Admission on AR must leave room for every read that later lands
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> cnt_q < 2'(Depth));

endmodule

//--- axi_lite_write_sub.sv
/*
  AXI4-Lite write subordinate
  AW and W join in any order, strobed write to the array, then B
*/
`timescale 1ns/1ps

module axi_lite_write_sub #(
  parameter int unsigned Words = axi_lite_pkg::DEF_WORDS
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  axi_lite_pkg::addr_t aw_addr_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_lite_pkg::data_t w_data_i,
  input  axi_lite_pkg::strb_t w_strb_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  output axi_lite_pkg::resp_t b_resp_o,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  // Memory port
  output logic                mem_req_o,
  output axi_lite_pkg::addr_t mem_addr_o,
  output axi_lite_pkg::data_t mem_wdata_o,
  output axi_lite_pkg::strb_t mem_strb_o,
  input  logic                mem_gnt_i
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_COLLECT,
    WR_WRITE,
    WR_RESP
  } wr_state_e;

  wr_state_e           state_q;
  wr_state_e           state_d;
  logic                aw_held_q;
  logic                w_held_q;
  logic                in_range_q;
  logic                gnt_q;
  axi_lite_pkg::addr_t addr_q;
  axi_lite_pkg::data_t data_q;
  axi_lite_pkg::strb_t strb_q;
  logic                aw_hs;
  logic                w_hs;
  logic                accepting;

  // --------------------
  // Channel capture
  // --------------------

  // Each channel is taken once per transaction, never while B waits
  assign accepting  = (state_q == WR_IDLE) || (state_q == WR_COLLECT);
  assign aw_ready_o = accepting & ~aw_held_q;
  assign w_ready_o  = accepting & ~w_held_q;
  assign aw_hs      = aw_valid_i & aw_ready_o;
  assign w_hs       = w_valid_i & w_ready_o;

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      addr_q <= aw_addr_i;
    end
    if (w_hs) begin
      data_q <= w_data_i;
      strb_q <= w_strb_i;
    end
  end

  // --------------------
  // FSM
  // --------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE, WR_COLLECT: begin
        if ((aw_held_q | aw_hs) && (w_held_q | w_hs)) begin
          state_d = WR_WRITE;
        end else if (aw_hs | w_hs) begin
          state_d = WR_COLLECT;
        end
      end
      // Out of range skips the array, in range waits one cycle past the grant
      WR_WRITE: if (!in_range_q || gnt_q) state_d = WR_RESP;
      WR_RESP:  if (b_ready_i) state_d = WR_IDLE;
      default:  state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= WR_IDLE;
      aw_held_q  <= 1'b0;
      w_held_q   <= 1'b0;
      in_range_q <= 1'b0;
      gnt_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == WR_RESP && b_ready_i) begin
        aw_held_q <= 1'b0;
        w_held_q  <= 1'b0;
      end else begin
        aw_held_q <= aw_held_q | aw_hs;
        w_held_q  <= w_held_q | w_hs;
      end
      if (aw_hs) begin
        in_range_q <= (aw_addr_i >> 2) < axi_lite_pkg::addr_t'(Words);
      end
      gnt_q <= (state_q == WR_WRITE) & (gnt_q | (mem_req_o & mem_gnt_i));
    end
  end

  // --------------------
  // Outputs
  // --------------------

  assign mem_req_o   = (state_q == WR_WRITE) & in_range_q & ~gnt_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = data_q;
  assign mem_strb_o  = strb_q;

  assign b_valid_o = (state_q == WR_RESP);
  assign b_resp_o  = in_range_q ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;

  // Arbiter grants only a live request, and never while B is pending
  a_no_req_in_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_gnt_i |-> mem_req_o && !b_valid_o);

endmodule

//--- axi_rw_split.sv
/*
  Read/write split of one AXI4-Lite port
  with an outstanding-transaction limit per direction
*/
`timescale 1ns/1ps

module axi_rw_split #(
  parameter int unsigned MaxTxns = axi_lite_pkg::DEF_MAX_TXNS
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Combined port, manager side
  input  axi_lite_pkg::addr_t aw_addr_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_lite_pkg::data_t w_data_i,
  input  axi_lite_pkg::strb_t w_strb_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  output axi_lite_pkg::resp_t b_resp_o,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  input  axi_lite_pkg::addr_t ar_addr_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  output axi_lite_pkg::data_t r_data_o,
  output axi_lite_pkg::resp_t r_resp_o,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  // Read side
  output axi_lite_pkg::addr_t rd_ar_addr_o,
  output logic                rd_ar_valid_o,
  input  logic                rd_ar_ready_i,
  input  axi_lite_pkg::data_t rd_r_data_i,
  input  axi_lite_pkg::resp_t rd_r_resp_i,
  input  logic                rd_r_valid_i,
  output logic                rd_r_ready_o,
  // Write side
  output axi_lite_pkg::addr_t wr_aw_addr_o,
  output logic                wr_aw_valid_o,
  input  logic                wr_aw_ready_i,
  output axi_lite_pkg::data_t wr_w_data_o,
  output axi_lite_pkg::strb_t wr_w_strb_o,
  output logic                wr_w_valid_o,
  input  logic                wr_w_ready_i,
  input  axi_lite_pkg::resp_t wr_b_resp_i,
  input  logic                wr_b_valid_i,
  output logic                wr_b_ready_o
);

  localparam int unsigned CntW = $clog2(MaxTxns + 1);
  typedef logic [CntW-1:0] cnt_t;

  // Index 0 counts reads, index 1 counts writes
  logic [1:0] inc;
  logic [1:0] dec;
  logic [1:0] full;
  cnt_t       cnt_q [2];

  // --------------------
  // Read channels
  // --------------------

  // AR is held off at the limit, R passes straight through
  assign rd_ar_addr_o  = ar_addr_i;
  assign rd_ar_valid_o = ar_valid_i & ~full[0];
  assign ar_ready_o    = rd_ar_ready_i & ~full[0];
  assign r_data_o      = rd_r_data_i;
  assign r_resp_o      = rd_r_resp_i;
  assign r_valid_o     = rd_r_valid_i;
  assign rd_r_ready_o  = r_ready_i;

  // --------------------
  // Write channels
  // --------------------

  // Only AW is limited; W waits in the write side until AW arrives
  assign wr_aw_addr_o  = aw_addr_i;
  assign wr_aw_valid_o = aw_valid_i & ~full[1];
  assign aw_ready_o    = wr_aw_ready_i & ~full[1];
  assign wr_w_data_o   = w_data_i;
  assign wr_w_strb_o   = w_strb_i;
  assign wr_w_valid_o  = w_valid_i;
  assign w_ready_o     = wr_w_ready_i;
  assign b_resp_o      = wr_b_resp_i;
  assign b_valid_o     = wr_b_valid_i;
  assign wr_b_ready_o  = b_ready_i;

  // --------------------
  // Outstanding counters
  // --------------------

  // Address handshake opens a transaction, response handshake closes it
  assign inc[0] = ar_valid_i & ar_ready_o;
  assign dec[0] = rd_r_valid_i & r_ready_i;
  assign inc[1] = aw_valid_i & aw_ready_o;
  assign dec[1] = wr_b_valid_i & b_ready_i;

  assign full[0] = (cnt_q[0] == cnt_t'(MaxTxns));
  assign full[1] = (cnt_q[1] == cnt_t'(MaxTxns));

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (inc[i] && !dec[i]) begin
        cnt_q[i] <= cnt_q[i] + cnt_t'(1);
      end else if (dec[i] && !inc[i]) begin
        cnt_q[i] <= cnt_q[i] - cnt_t'(1);
      end
    end
  end

  // A response needs a matching address beat accepted earlier
  a_r_needs_ar: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_r_valid_i |-> cnt_q[0] != '0);
  a_b_needs_aw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_b_valid_i |-> cnt_q[1] != '0);
  a_cnt_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q[0] <= cnt_t'(MaxTxns) && cnt_q[1] <= cnt_t'(MaxTxns));

endmodule

//--- project.f
axi_lite_pkg.sv
axi_rw_split.sv
axi_lite_read_sub.sv
axi_lite_write_sub.sv
reg_mem.sv
axi_lite_mem_top.sv
tb_axi_lite_mem_top.sv

//--- reg_mem.sv
/*
  Single-port register array with round-robin read/write arbiter
*/
`timescale 1ns/1ps

module reg_mem #(
  parameter int unsigned Words = axi_lite_pkg::DEF_WORDS
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                rd_req_i,
  input  axi_lite_pkg::addr_t rd_addr_i,
  output logic                rd_gnt_o,
  output axi_lite_pkg::data_t rd_data_o,
  input  logic                wr_req_i,
  input  axi_lite_pkg::addr_t wr_addr_i,
  input  axi_lite_pkg::data_t wr_data_i,
  input  axi_lite_pkg::strb_t wr_strb_i,
  output logic                wr_gnt_o
);

  localparam int unsigned IdxW = (Words > 1) ? $clog2(Words) : 1;
  typedef logic [IdxW-1:0] idx_t;

  typedef enum logic {
    LAST_RD,
    LAST_WR
  } arb_last_e;

  arb_last_e           last_q;
  axi_lite_pkg::data_t mem_q [Words];
  idx_t                rd_idx;
  idx_t                wr_idx;

  // Word index from the byte address
  assign rd_idx = rd_addr_i[IdxW+1:2];
  assign wr_idx = wr_addr_i[IdxW+1:2];

  // --------------------
  // Arbiter
  // --------------------

  // On a conflict the side not served last time wins
  assign rd_gnt_o = rd_req_i & (~wr_req_i | (last_q == LAST_WR));
  assign wr_gnt_o = wr_req_i & (~rd_req_i | (last_q == LAST_RD));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q <= LAST_WR;
    end else if (rd_gnt_o) begin
      last_q <= LAST_RD;
    end else if (wr_gnt_o) begin
      last_q <= LAST_WR;
    end
  end

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < Words; w++) begin
        mem_q[w] <= '0;
      end
    end else if (wr_gnt_o) begin
      // Only strobed bytes change
      for (int b = 0; b < 4; b++) begin
        if (wr_strb_i[b]) mem_q[wr_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
      end
    end
  end

  // Read word lands one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (rd_gnt_o) begin
      rd_data_o <= mem_q[rd_idx];
    end
  end

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rd_gnt_o && wr_gnt_o));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_axi_lite_mem_top

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module "$TOP" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
fi
exit 1

//--- tb_axi_lite_mem_top.sv
/*
  Directed testbench for the AXI4-Lite register store
  with a reference model of the register array
*/
`timescale 1ns/1ps

module tb_axi_lite_mem_top;

  localparam int unsigned Words   = 16;
  localparam int unsigned MaxTxns = 2;
  // Cycles any single wait may take
  localparam int MaxWait = 50;
  // Word index beyond the array
  localparam int OorIdx  = 20;

  logic                clk;
  logic                rst_n;
  axi_lite_pkg::addr_t aw_addr;
  logic                aw_valid;
  logic                aw_ready_o;
  axi_lite_pkg::data_t w_data;
  axi_lite_pkg::strb_t w_strb;
  logic                w_valid;
  logic                w_ready_o;
  axi_lite_pkg::resp_t b_resp_o;
  logic                b_valid_o;
  logic                b_ready;
  axi_lite_pkg::addr_t ar_addr;
  logic                ar_valid;
  logic                ar_ready_o;
  axi_lite_pkg::data_t r_data_o;
  axi_lite_pkg::resp_t r_resp_o;
  logic                r_valid_o;
  logic                r_ready;

  axi_lite_pkg::data_t model [Words];
  integer              seed;
  int                  errors;
  int                  checks;

  axi_lite_mem_top #(
    .Words  (Words),
    .MaxTxns(MaxTxns)
  ) UUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .aw_addr_i (aw_addr),
    .aw_valid_i(aw_valid),
    .aw_ready_o(aw_ready_o),
    .w_data_i  (w_data),
    .w_strb_i  (w_strb),
    .w_valid_i (w_valid),
    .w_ready_o (w_ready_o),
    .b_resp_o  (b_resp_o),
    .b_valid_o (b_valid_o),
    .b_ready_i (b_ready),
    .ar_addr_i (ar_addr),
    .ar_valid_i(ar_valid),
    .ar_ready_o(ar_ready_o),
    .r_data_o  (r_data_o),
    .r_resp_o  (r_resp_o),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // --------------------
  // Model helpers
  // --------------------

  // Each set strobe bit replaces one byte of the old word
  function automatic axi_lite_pkg::data_t apply_strobes(input axi_lite_pkg::data_t old_w,
                                                        input axi_lite_pkg::data_t new_w,
                                                        input axi_lite_pkg::strb_t strb);
    axi_lite_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic axi_lite_pkg::addr_t addr_of(input int idx);
    return axi_lite_pkg::addr_t'(idx) << 2;
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // --------------------
  // Channel tasks
  // --------------------

  // Ready is sampled at the falling edge, the beat moves on the next rising edge
  task automatic send_aw(input string name, input axi_lite_pkg::addr_t addr);
    int n;
    n        = 0;
    aw_addr  = addr;
    aw_valid = 1'b1;
    @(negedge clk);
    while (!aw_ready_o && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (!aw_ready_o) begin
      errors++;
      $display("Timeout in %s: aw_ready_o stayed low for %0d cycles", name, MaxWait);
    end
    step();
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input string name, input axi_lite_pkg::data_t data,
                        input axi_lite_pkg::strb_t strb);
    int n;
    n       = 0;
    w_data  = data;
    w_strb  = strb;
    w_valid = 1'b1;
    @(negedge clk);
    while (!w_ready_o && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (!w_ready_o) begin
      errors++;
      $display("Timeout in %s: w_ready_o stayed low for %0d cycles", name, MaxWait);
    end
    step();
    w_valid = 1'b0;
  endtask

  task automatic send_ar(input string name, input axi_lite_pkg::addr_t addr);
    int n;
    n        = 0;
    ar_addr  = addr;
    ar_valid = 1'b1;
    @(negedge clk);
    while (!ar_ready_o && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (!ar_ready_o) begin
      errors++;
      $display("Timeout in %s: ar_ready_o stayed low for %0d cycles", name, MaxWait);
    end
    step();
    ar_valid = 1'b0;
  endtask

  task automatic recv_b(input string name, input axi_lite_pkg::resp_t exp_resp);
    int n;
    n       = 0;
    b_ready = 1'b1;
    @(negedge clk);
    while (!b_valid_o && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (!b_valid_o) begin
      errors++;
      $display("Timeout in %s: no write response within %0d cycles", name, MaxWait);
    end else begin
      checks++;
      if (b_resp_o !== exp_resp) begin
        errors++;
        $display("Fail %s: B resp expected %0d, actual %0d", name, exp_resp, b_resp_o);
      end
    end
    step();
    b_ready = 1'b0;
  endtask

  task automatic recv_r(input string name, input axi_lite_pkg::data_t exp_data,
                        input axi_lite_pkg::resp_t exp_resp);
    int n;
    n       = 0;
    r_ready = 1'b1;
    @(negedge clk);
    while (!r_valid_o && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (!r_valid_o) begin
      errors++;
      $display("Timeout in %s: no read response within %0d cycles", name, MaxWait);
    end else begin
      checks++;
      if (r_data_o !== exp_data) begin
        errors++;
        $display("Fail %s: R data expected %h, actual %h", name, exp_data, r_data_o);
      end
      if (r_resp_o !== exp_resp) begin
        errors++;
        $display("Fail %s: R resp expected %0d, actual %0d", name, exp_resp, r_resp_o);
      end
    end
    step();
    r_ready = 1'b0;
  endtask

  // AW and W together, then B; in-range words update the model
  task automatic write_word(input string name, input int idx, input axi_lite_pkg::data_t data,
                            input axi_lite_pkg::strb_t strb);
    fork
      send_aw(name, addr_of(idx));
      send_w(name, data, strb);
    join
    if (idx < int'(Words)) begin
      recv_b(name, axi_lite_pkg::RESP_OKAY);
      model[idx] = apply_strobes(model[idx], data, strb);
    end else begin
      recv_b(name, axi_lite_pkg::RESP_SLVERR);
    end
  endtask

  // Out-of-range reads expect zero data with SLVERR
  task automatic read_word(input string name, input int idx);
    axi_lite_pkg::data_t exp_data;
    axi_lite_pkg::resp_t exp_resp;
    exp_data = (idx < int'(Words)) ? model[idx] : '0;
    exp_resp = (idx < int'(Words)) ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
    send_ar(name, addr_of(idx));
    recv_r(name, exp_data, exp_resp);
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic write_readback();
    for (int i = 0; i < 6; i++) begin
      write_word("write_readback", i * 3, $random(seed), 4'hF);
    end
    for (int i = 0; i < 6; i++) begin
      read_word("write_readback", i * 3);
    end
  endtask

  task automatic byte_strobes();
    write_word("byte_strobes", 5, $random(seed), 4'hF);
    read_word("byte_strobes", 5);
    write_word("byte_strobes", 5, $random(seed), 4'b0101);
    read_word("byte_strobes", 5);
    write_word("byte_strobes", 5, $random(seed), 4'b1000);
    read_word("byte_strobes", 5);
  endtask

  // Index 20 would alias to word 4 if the range check were missing
  task automatic out_of_range();
    write_word("out_of_range", OorIdx, $random(seed), 4'hF);
    read_word("out_of_range", OorIdx);
    read_word("out_of_range", OorIdx % int'(Words));
  endtask

  task automatic read_backpressure();
    string name;
    name = "read_backpressure";
    // r_ready stays low, two reads fill the limit
    send_ar(name, addr_of(3));
    send_ar(name, addr_of(12));
    ar_addr  = addr_of(6);
    ar_valid = 1'b1;
    repeat (8) begin
      @(negedge clk);
      checks++;
      if (ar_ready_o) begin
        errors++;
        $display("Fail %s: ar_ready_o expected 0, actual 1", name);
      end
    end
    step();
    // Third AR goes through once the first response drains
    fork
      send_ar(name, addr_of(6));
      begin
        recv_r(name, model[3], axi_lite_pkg::RESP_OKAY);
        recv_r(name, model[12], axi_lite_pkg::RESP_OKAY);
      end
    join
    recv_r(name, model[6], axi_lite_pkg::RESP_OKAY);
  endtask

  task automatic concurrent_rw();
    axi_lite_pkg::data_t d;
    d = $random(seed);
    fork
      write_word("concurrent_rw", 8, d, 4'hF);
      read_word("concurrent_rw", 9);
    join
    read_word("concurrent_rw", 8);
  endtask

  task automatic w_before_aw();
    string               name;
    axi_lite_pkg::data_t d;
    int                  n;
    name = "w_before_aw";
    d    = $random(seed);
    send_w(name, d, 4'hF);
    // W sits alone for a few cycles
    repeat (4) step();
    send_aw(name, addr_of(11));
    n = 0;
    @(negedge clk);
    while (!b_valid_o && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (!b_valid_o) begin
      errors++;
      $display("Timeout in %s: B never became valid", name);
    end
    // B held back, both ready outputs must stay low
    repeat (5) begin
      checks++;
      if (aw_ready_o || w_ready_o) begin
        errors++;
        $display("Fail %s: aw/w ready expected 0/0, actual %b/%b", name, aw_ready_o, w_ready_o);
      end
      @(negedge clk);
    end
    step();
    recv_b(name, axi_lite_pkg::RESP_OKAY);
    model[11] = apply_strobes(model[11], d, 4'hF);
    @(negedge clk);
    checks++;
    if (!aw_ready_o || !w_ready_o) begin
      errors++;
      $display("Fail %s: aw/w ready expected 1/1, actual %b/%b", name, aw_ready_o, w_ready_o);
    end
    step();
    read_word(name, 11);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    aw_addr  = '0;
    aw_valid = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_addr  = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    seed     = 32'h54e6;
    errors   = 0;
    checks   = 0;
    for (int i = 0; i < int'(Words); i++) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();

    // Idle state after reset
    @(negedge clk);
    checks++;
    if (b_valid_o || r_valid_o || !aw_ready_o || !w_ready_o || !ar_ready_o) begin
      errors++;
      $display("Fail reset: b/r valid, aw/w/ar ready expected 00111, actual %b%b%b%b%b",
               b_valid_o, r_valid_o, aw_ready_o, w_ready_o, ar_ready_o);
    end
    step();

    write_readback();
    byte_strobes();
    out_of_range();
    read_backpressure();
    concurrent_rw();
    w_before_aw();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
